/* logic/cdr_cfg.svh */
`ifndef CDR_CFG_SVH
`define CDR_CFG_SVH

//////////////////////////////////////////////////
// frame geometry
//////////////////////////////////////////////////

`define CDR_NTI       4     // interleaved lanes per frame
`define CDR_NADC      8     // signed adc code width

//////////////////////////////////////////////////
// loop widths
//////////////////////////////////////////////////

`define CDR_NPI       8     // phase interpolator code width
`define CDR_PH_SHIFT  12    // fraction bits below the pi code

// four cross terms of two products each need 4 growth bits
`define CDR_NERR      (`CDR_NADC + 4)

// error, full gain headroom and fraction, plus sign and guard
`define CDR_NEST      (`CDR_NERR + `CDR_PH_SHIFT + 2)

`define CDR_NSHIFT    4     // kp / ki shift field width

`endif

/* logic/cdr_pkg.sv */
`include "cdr_cfg.svh"

package cdr_pkg;

    //////////////////////////////////////////////////
    // datapath vectors
    //////////////////////////////////////////////////

    typedef logic signed [`CDR_NADC-1:0]          adc_code_t;
    typedef logic [`CDR_NTI*`CDR_NADC-1:0]        code_frame_t;   // lane 0 in the low bits
    typedef logic [`CDR_NTI-1:0]                  bit_frame_t;    // slicer decisions, 1 is +1
    typedef logic signed [`CDR_NERR-1:0]          phase_err_t;
    typedef logic signed [`CDR_NEST-1:0]          est_t;          // phase / freq accumulators
    typedef logic [`CDR_NPI-1:0]                  pi_code_t;

    //////////////////////////////////////////////////
    // debug control and snapshot
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [`CDR_NSHIFT-1:0] kp;           // proportional gain shift
        logic [`CDR_NSHIFT-1:0] ki;           // integral gain shift
        logic                   en_freq_est;
        logic                   en_clamp;
        est_t                   clamp_amt;    // symmetric limit on the phase step
        logic                   en_ext_pi;
        pi_code_t               ext_pi;
        logic                   sample_req;   // level, not a pulse
    } cdr_ctl_t;

    typedef struct packed {
        pi_code_t phase;
        est_t     freq;
    } cdr_snap_t;

    typedef enum logic [1:0] {
        WAIT,
        READY,
        SAMPLE
    } sampler_state_t;

endpackage

/* logic/mm_phase_det.sv */
`include "cdr_cfg.svh"

module mm_phase_det (
    input  logic                  clk,
    input  logic                  ext_rstb,
    input  cdr_pkg::code_frame_t  codes_i,
    input  cdr_pkg::bit_frame_t   bits_i,
    output cdr_pkg::phase_err_t   pd_err_o
);

    // heap-ordered adder tree, leaves sit at the top NTI slots
    localparam int NODES = 2 * `CDR_NTI - 1;
    localparam int LEAF0 = `CDR_NTI - 1;

    cdr_pkg::adc_code_t   lane_code [`CDR_NTI];
    cdr_pkg::phase_err_t  code_ext  [`CDR_NTI+1];   // slot 0 is last lane of prior frame
    logic [`CDR_NTI:0]    dec_all;                  // same ordering as code_ext
    cdr_pkg::phase_err_t  tree      [NODES];

    cdr_pkg::adc_code_t   prev_code_q;
    logic                 prev_dec_q;

    //////////////////////////////////////////////////
    // lane unpacking
    //////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < `CDR_NTI; k++) begin
            lane_code[k] = codes_i[k*`CDR_NADC +: `CDR_NADC];
        end
    end

    always_comb begin
        code_ext[0] = prev_code_q;                  // sign extends
        for (int k = 0; k < `CDR_NTI; k++) begin
            code_ext[k+1] = lane_code[k];
        end
        dec_all = {bits_i, prev_dec_q};
    end

    //////////////////////////////////////////////////
    // cross products and reduction
    //////////////////////////////////////////////////

    // term k = code[k]*d[k-1] - code[k-1]*d[k], with d = +1 / -1
    always_comb begin
        cdr_pkg::phase_err_t cross_a;
        cdr_pkg::phase_err_t cross_b;
        for (int k = 0; k < `CDR_NTI; k++) begin
            cross_a = dec_all[k]   ? code_ext[k+1] : -code_ext[k+1];
            cross_b = dec_all[k+1] ? code_ext[k]   : -code_ext[k];
            tree[LEAF0 + k] = cross_a - cross_b;
        end
        for (int i = `CDR_NTI - 2; i >= 0; i--) begin
            tree[i] = tree[2*i+1] + tree[2*i+2];
        end
    end

    //////////////////////////////////////////////////
    // output register and frame wrap state
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            pd_err_o    <= '0;
            prev_code_q <= '0;
            prev_dec_q  <= 1'b0;                    // decodes as -1 before first frame
        end else begin
            pd_err_o    <= tree[0];
            prev_code_q <= lane_code[`CDR_NTI-1];
            prev_dec_q  <= bits_i[`CDR_NTI-1];
        end
    end

endmodule

/* logic/cdr_loop_filter.sv */
`include "cdr_cfg.svh"

module cdr_loop_filter (
    input  logic                clk,
    input  logic                ext_rstb,
    input  cdr_pkg::phase_err_t pd_err_i,
    input  cdr_pkg::cdr_ctl_t   ctl_i,
    output cdr_pkg::pi_code_t   pi_ctl_o,
    output cdr_pkg::pi_code_t   phase_code_o,
    output cdr_pkg::est_t       freq_update_o,
    output logic                freq_lvl_cross_o
);

    cdr_pkg::phase_err_t err_q;         // detector error, loop sign applied
    cdr_pkg::est_t       err_ext;

    cdr_pkg::est_t       freq_update;
    cdr_pkg::est_t       freq_d;
    cdr_pkg::est_t       freq_acc_q;
    cdr_pkg::est_t       prev_freq_upd_q;

    cdr_pkg::est_t       phase_update;
    cdr_pkg::est_t       phase_step;    // after optional clamp
    cdr_pkg::est_t       phase_d;
    cdr_pkg::est_t       phase_acc_q;

    cdr_pkg::est_t       clamp_hi;
    cdr_pkg::est_t       clamp_lo;
    cdr_pkg::est_t       ext_est;

    logic                lvl_cross_q;

    //////////////////////////////////////////////////
    // integral and proportional paths
    //////////////////////////////////////////////////

    always_comb begin
        err_ext      = err_q;                                   // sign extends
        freq_update  = err_ext <<< ctl_i.ki;
        freq_d       = freq_acc_q + (ctl_i.en_freq_est ? freq_update : '0);
        phase_update = (err_ext <<< ctl_i.kp) + freq_acc_q;     // uses freq before this update
    end

    //////////////////////////////////////////////////
    // step clamp
    //////////////////////////////////////////////////

    always_comb begin
        clamp_hi = ctl_i.clamp_amt;
        clamp_lo = -clamp_hi;
        if (ctl_i.en_clamp) begin
            if (phase_update > clamp_hi) begin
                phase_step = clamp_hi;
            end else if (phase_update < clamp_lo) begin
                phase_step = clamp_lo;
            end else begin
                phase_step = phase_update;
            end
        end else begin
            phase_step = phase_update;
        end
    end

    // accumulator wraps, matching the periodic interpolator phase
    assign phase_d = phase_acc_q + phase_step;

    // override code placed in the integer part of the accumulator
    always_comb begin
        ext_est = ctl_i.ext_pi;                                 // zero extends
        ext_est = ext_est <<< `CDR_PH_SHIFT;
    end

    //////////////////////////////////////////////////
    // loop state
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            err_q           <= '0;
            freq_acc_q      <= '0;
            phase_acc_q     <= '0;
            prev_freq_upd_q <= '0;
            lvl_cross_q     <= 1'b0;
        end else begin
            err_q           <= -pd_err_i;   // detector polarity is opposite to the loop
            freq_acc_q      <= freq_d;
            if (ctl_i.en_ext_pi) begin
                phase_acc_q <= ext_est;
            end else begin
                phase_acc_q <= phase_d;
            end
            prev_freq_upd_q <= freq_update;
            lvl_cross_q     <= (freq_update > prev_freq_upd_q);
        end
    end

    //////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////

    assign phase_code_o     = phase_acc_q[`CDR_PH_SHIFT +: `CDR_NPI];
    assign pi_ctl_o         = ctl_i.en_ext_pi ? ctl_i.ext_pi : phase_code_o;
    assign freq_update_o    = freq_update;
    assign freq_lvl_cross_o = lvl_cross_q;

endmodule

/* logic/cdr_state_sampler.sv */
module cdr_state_sampler (
    input  logic                clk,
    input  logic                ext_rstb,
    input  logic                sample_req_i,
    input  cdr_pkg::pi_code_t   phase_code_i,
    input  cdr_pkg::est_t       freq_update_i,
    output cdr_pkg::cdr_snap_t  snap_o,
    output logic                snap_valid_o
);

    cdr_pkg::sampler_state_t state_q;
    cdr_pkg::cdr_snap_t      snap_q;
    logic                    captured_q;    // at least one snapshot taken

    //////////////////////////////////////////////////
    // request FSM
    //////////////////////////////////////////////////

    // a low request arms the FSM, a high one fires a single capture
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            state_q    <= cdr_pkg::WAIT;
            snap_q     <= '0;
            captured_q <= 1'b0;
        end else begin
            case (state_q)
                cdr_pkg::WAIT: begin
                    if (!sample_req_i) begin
                        state_q <= cdr_pkg::READY;
                    end
                end
                cdr_pkg::READY: begin
                    if (sample_req_i) begin
                        state_q <= cdr_pkg::SAMPLE;
                    end
                end
                cdr_pkg::SAMPLE: begin
                    snap_q.phase <= phase_code_i;
                    snap_q.freq  <= freq_update_i;
                    captured_q   <= 1'b1;
                    state_q      <= cdr_pkg::WAIT;
                end
                default: begin
                    state_q <= cdr_pkg::WAIT;
                end
            endcase
        end
    end

    assign snap_o       = snap_q;
    assign snap_valid_o = captured_q && (state_q == cdr_pkg::WAIT);   // stable for readout

endmodule

/* logic/mm_cdr_top.sv */
module mm_cdr_top (
    input  logic                  clk,
    input  logic                  ext_rstb,
    input  cdr_pkg::code_frame_t  codes_i,
    input  cdr_pkg::bit_frame_t   bits_i,
    input  cdr_pkg::cdr_ctl_t     ctl_i,
    output cdr_pkg::pi_code_t     pi_ctl_o,
    output logic                  freq_lvl_cross_o,
    output cdr_pkg::cdr_snap_t    snap_o,
    output logic                  snap_valid_o
);

    cdr_pkg::phase_err_t pd_err;
    cdr_pkg::pi_code_t   phase_code;     // accumulator code, ignores override
    cdr_pkg::est_t       freq_update;

    //////////////////////////////////////////////////
    // phase detector
    //////////////////////////////////////////////////

    mm_phase_det u_phase_det (
        .clk      (clk),
        .ext_rstb (ext_rstb),
        .codes_i  (codes_i),
        .bits_i   (bits_i),
        .pd_err_o (pd_err)
    );

    //////////////////////////////////////////////////
    // second order loop
    //////////////////////////////////////////////////

    cdr_loop_filter u_loop_filter (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .pd_err_i         (pd_err),
        .ctl_i            (ctl_i),
        .pi_ctl_o         (pi_ctl_o),
        .phase_code_o     (phase_code),
        .freq_update_o    (freq_update),
        .freq_lvl_cross_o (freq_lvl_cross_o)
    );

    //////////////////////////////////////////////////
    // debug snapshot, taps the loop
    //////////////////////////////////////////////////

    cdr_state_sampler u_state_sampler (
        .clk           (clk),
        .ext_rstb      (ext_rstb),
        .sample_req_i  (ctl_i.sample_req),
        .phase_code_i  (phase_code),
        .freq_update_i (freq_update),
        .snap_o        (snap_o),
        .snap_valid_o  (snap_valid_o)
    );

endmodule

/* tb/mm_cdr_props.sv */
module mm_cdr_props (
    input logic                    clk,
    input logic                    ext_rstb,
    input cdr_pkg::sampler_state_t state,
    input cdr_pkg::cdr_snap_t      snap,
    input logic                    en_ext_pi,
    input cdr_pkg::pi_code_t       ext_pi,
    input cdr_pkg::pi_code_t       phase_code
);

    sample_one_cycle: assert property (@(posedge clk) disable iff (!ext_rstb)
        state == cdr_pkg::SAMPLE |=> state != cdr_pkg::SAMPLE)
        else $error("sampler held SAMPLE for more than one cycle");

    // snapshot register only moves on the edge that leaves SAMPLE
    snap_after_sample: assert property (@(posedge clk) disable iff (!ext_rstb)
        !$stable(snap) |-> $past(state) == cdr_pkg::SAMPLE)
        else $error("snapshot changed without a SAMPLE cycle");

    // override loads the accumulator so tracking restarts from that code
    override_loads_acc: assert property (@(posedge clk) disable iff (!ext_rstb)
        en_ext_pi |=> phase_code == $past(ext_pi))
        else $error("accumulator code did not take the override code");

endmodule

bind cdr_state_sampler mm_cdr_props sampler_props_i (
    .clk (clk), .ext_rstb (ext_rstb), .state (state_q), .snap (snap_o),
    .en_ext_pi (1'b0), .ext_pi (cdr_pkg::pi_code_t'(0)),
    .phase_code (cdr_pkg::pi_code_t'(0))
);

bind cdr_loop_filter mm_cdr_props filter_props_i (
    .clk (clk), .ext_rstb (ext_rstb), .state (cdr_pkg::WAIT), .snap (cdr_pkg::cdr_snap_t'(0)),
    .en_ext_pi (ctl_i.en_ext_pi), .ext_pi (ctl_i.ext_pi), .phase_code (phase_code_o)
);

/* tb/tb_mm_cdr.sv */
`include "cdr_cfg.svh"

module tb_mm_cdr;

    localparam int RESET_CYC = 5;
    localparam int T_RESET   = 10;
    localparam int T_PROP    = 200;
    localparam int T_SECOND  = 200;
    localparam int T_CLAMP   = 150;
    localparam int T_OVR     = 80;
    localparam int SNAP_WAIT = 8;
    localparam int T_SNAP    = 2 * (4 + SNAP_WAIT);
    localparam int WDOG_CYC  = RESET_CYC + T_RESET + T_PROP + T_SECOND + T_CLAMP
                               + T_OVR + T_SNAP + 50;

    typedef struct packed {
        cdr_pkg::adc_code_t      prev_code;
        logic                    prev_dec;
        cdr_pkg::phase_err_t     pd_err;
        cdr_pkg::phase_err_t     err_q;
        cdr_pkg::est_t           freq_acc;
        cdr_pkg::est_t           phase_acc;
        cdr_pkg::est_t           prev_fu;
        logic                    lvl;
        cdr_pkg::sampler_state_t smp_state;
        cdr_pkg::cdr_snap_t      snap;
        logic                    captured;
    } model_t;

    logic clk, ext_rstb, freq_lvl_cross_o, snap_valid_o, check_on, clamp_watch;
    cdr_pkg::code_frame_t codes_i;
    cdr_pkg::bit_frame_t  bits_i;
    cdr_pkg::cdr_ctl_t    ctl_i;
    cdr_pkg::pi_code_t    pi_ctl_o, pi_prev;
    cdr_pkg::cdr_snap_t   snap_o;
    model_t               m;
    logic [31:0]          lfsr;
    string                cur_test;
    int                   test_errs, total_errs, tests_run, tests_failed;

    mm_cdr_top dut_i (
        .clk (clk), .ext_rstb (ext_rstb), .codes_i (codes_i), .bits_i (bits_i),
        .ctl_i (ctl_i), .pi_ctl_o (pi_ctl_o), .freq_lvl_cross_o (freq_lvl_cross_o),
        .snap_o (snap_o), .snap_valid_o (snap_valid_o)
    );

    always #10 clk = ~clk;

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic longint wrap_est(longint v);
        cdr_pkg::est_t t;
        t = v[`CDR_NEST-1:0];
        return t;                                   // back to signed
    endfunction

    function automatic cdr_pkg::pi_code_t code_of(cdr_pkg::est_t acc);
        longint whole;
        whole = longint'(acc) >>> `CDR_PH_SHIFT;
        return whole[`CDR_NPI-1:0];
    endfunction

    function automatic cdr_pkg::pi_code_t pi_expect(model_t s, cdr_pkg::cdr_ctl_t ctl);
        return ctl.en_ext_pi ? ctl.ext_pi : code_of(s.phase_acc);
    endfunction

    // one clock edge of detector, loop and sampler from pre-edge state
    function automatic model_t model_step(model_t s, cdr_pkg::code_frame_t codes,
                                          cdr_pkg::bit_frame_t bits, cdr_pkg::cdr_ctl_t ctl);
        model_t             n;
        cdr_pkg::adc_code_t lane;
        longint             code_prv, code_cur, d_prv, d_cur, err_sum, fu, upd, lim;
        n        = s;
        code_prv = s.prev_code;
        d_prv    = s.prev_dec ? 1 : -1;
        err_sum  = 0;
        for (int k = 0; k < `CDR_NTI; k++) begin
            lane     = codes[k*`CDR_NADC +: `CDR_NADC];
            code_cur = lane;
            d_cur    = bits[k] ? 1 : -1;
            err_sum += code_cur * d_prv - code_prv * d_cur;
            code_prv = code_cur;
            d_prv    = d_cur;
        end
        n.pd_err    = err_sum;
        n.prev_code = lane;                         // last lane wraps to next frame
        n.prev_dec  = bits[`CDR_NTI-1];
        n.err_q     = -longint'(s.pd_err);
        fu = wrap_est(longint'(s.err_q) <<< ctl.ki);
        if (ctl.en_freq_est) n.freq_acc = wrap_est(longint'(s.freq_acc) + fu);
        upd = wrap_est((longint'(s.err_q) <<< ctl.kp) + longint'(s.freq_acc));
        lim = ctl.clamp_amt;
        if (ctl.en_clamp && upd > lim) upd = lim;
        if (ctl.en_clamp && upd < -lim) upd = -lim;
        if (ctl.en_ext_pi) n.phase_acc = longint'(ctl.ext_pi) <<< `CDR_PH_SHIFT;
        else n.phase_acc = wrap_est(longint'(s.phase_acc) + upd);
        n.lvl     = fu > longint'(s.prev_fu);
        n.prev_fu = fu;
        case (s.smp_state)
            cdr_pkg::WAIT:  if (!ctl.sample_req) n.smp_state = cdr_pkg::READY;
            cdr_pkg::READY: if (ctl.sample_req) n.smp_state = cdr_pkg::SAMPLE;
            default: begin
                n.snap.phase = code_of(s.phase_acc);
                n.snap.freq  = fu;
                n.captured   = 1'b1;
                n.smp_state  = cdr_pkg::WAIT;
            end
        endcase
        return n;
    endfunction

    always @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) m <= '0;
        else m <= model_step(m, codes_i, bits_i, ctl_i);
    end

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////

    task automatic count_error();
        test_errs++;
        total_errs++;
    endtask

    // fibonacci register, the new bit enters at bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic drive_frame();
        logic [31:0] r;
        for (int k = 0; k < `CDR_NTI; k++) begin
            take_bits(`CDR_NADC, r);
            codes_i[k*`CDR_NADC +: `CDR_NADC] = r[`CDR_NADC-1:0];
            bits_i[k] = ~r[`CDR_NADC-1];            // decision is the code sign
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic run_frames(input int n);
        repeat (n) begin
            next_cycle();
            drive_frame();
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errs != 0) tests_failed++;
        $display("test %0d %s finished with %0d errors", tests_run, cur_test, test_errs);
    endtask

    //////////////////////////////////////////////////
    // mid-cycle comparator
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        int step;
        int lim;
        if (check_on) begin
            if (pi_ctl_o !== pi_expect(m, ctl_i)) begin
                $display("Mismatch %s pi_ctl_o: expected %0h actual %0h",
                         cur_test, pi_expect(m, ctl_i), pi_ctl_o);
                count_error();
            end
            if (freq_lvl_cross_o !== m.lvl) begin
                $display("Mismatch %s freq_lvl_cross_o: expected %0b actual %0b",
                         cur_test, m.lvl, freq_lvl_cross_o);
                count_error();
            end
            if (snap_valid_o !== (m.captured && m.smp_state == cdr_pkg::WAIT)) begin
                $display("Mismatch %s snap_valid_o: expected %0b actual %0b", cur_test,
                         m.captured && m.smp_state == cdr_pkg::WAIT, snap_valid_o);
                count_error();
            end
            if (snap_o !== m.snap) begin
                $display("Mismatch %s snap_o: expected %0h actual %0h", cur_test, m.snap, snap_o);
                count_error();
            end
            step = $signed(cdr_pkg::pi_code_t'(pi_ctl_o - pi_prev));   // wraps like the PI
            lim  = (ctl_i.clamp_amt >>> `CDR_PH_SHIFT) + 1;
            if (clamp_watch && (step > lim || step < -lim)) begin
                $display("%s: phase code moved by %0d, more than the clamp allows", cur_test, step);
                count_error();
            end
        end
        pi_prev = pi_ctl_o;
    end

    initial begin
        #(WDOG_CYC * 20);
        $display("timeout: run did not end within %0d cycles", WDOG_CYC);
        $display("SOME TESTS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        int waited;
        clk = 1'b0;
        ext_rstb = 1'b0;
        codes_i = '0;
        bits_i = '0;
        ctl_i = '0;
        lfsr = 32'h5613;
        check_on = 1'b0;
        clamp_watch = 1'b0;
        pi_prev = '0;
        {test_errs, total_errs, tests_run, tests_failed} = '0;
        repeat (RESET_CYC) @(posedge clk);
        #2 ext_rstb = 1'b1;

        start_test("reset_values");
        if (pi_ctl_o !== '0 || freq_lvl_cross_o !== 1'b0 || snap_valid_o !== 1'b0
            || snap_o !== '0) begin
            $display("Mismatch %s outputs: expected 0 actual pi %0h cross %0b valid %0b snap %0h",
                     cur_test, pi_ctl_o, freq_lvl_cross_o, snap_valid_o, snap_o);
            count_error();
        end
        check_on = 1'b1;
        repeat (T_RESET) next_cycle();
        finish_test();

        start_test("proportional_only");
        next_cycle();
        ctl_i.kp = 4'd3;
        ctl_i.ki = 4'd2;                            // integrator still disabled
        run_frames(T_PROP);
        finish_test();

        start_test("second_order");
        next_cycle();
        ctl_i.ki = 4'd1;
        ctl_i.en_freq_est = 1'b1;
        run_frames(T_SECOND);
        finish_test();

        start_test("step_clamp");
        next_cycle();
        ctl_i.en_clamp = 1'b1;
        ctl_i.clamp_amt = 3000;
        drive_frame();
        run_frames(1);
        clamp_watch = 1'b1;                         // first clamped step is visible from here
        run_frames(T_CLAMP);
        clamp_watch = 1'b0;
        ctl_i.en_clamp = 1'b0;
        finish_test();

        start_test("pi_override");
        next_cycle();
        ctl_i.en_ext_pi = 1'b1;
        ctl_i.ext_pi = 8'ha5;
        drive_frame();
        #1;
        if (pi_ctl_o !== 8'ha5) begin
            $display("Mismatch %s pi_ctl_o: expected a5 actual %0h", cur_test, pi_ctl_o);
            count_error();
        end
        run_frames(20);
        next_cycle();
        ctl_i.en_ext_pi = 1'b0;
        drive_frame();
        #1;
        if (pi_ctl_o !== 8'ha5) begin
            $display("Mismatch %s pi_ctl_o after release: expected a5 actual %0h",
                     cur_test, pi_ctl_o);
            count_error();
        end
        run_frames(T_OVR - 22);
        finish_test();

        start_test("debug_snapshot");
        for (int p = 0; p < 2; p++) begin
            next_cycle();
            ctl_i.sample_req = 1'b0;                // rearm
            drive_frame();
            run_frames(2);
            if (p > 0 && snap_valid_o !== 1'b0) begin
                $display("%s: snap_valid_o stayed high after the request went low", cur_test);
                count_error();
            end
            next_cycle();
            ctl_i.sample_req = 1'b1;
            drive_frame();
            waited = 0;
            @(negedge clk);
            while (snap_valid_o !== 1'b1 && waited < SNAP_WAIT) begin
                run_frames(1);
                @(negedge clk);
                waited++;
            end
            if (snap_valid_o !== 1'b1) begin
                $display("%s: no snapshot became valid after the request", cur_test);
                count_error();
            end else if (snap_o !== m.snap) begin
                $display("Mismatch %s snap_o: expected %0h actual %0h", cur_test, m.snap, snap_o);
                count_error();
            end
        end
        finish_test();

        $display("%0d tests run, %0d with errors, %0d errors in total",
                 tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+logic/
logic/cdr_pkg.sv
logic/mm_phase_det.sv
logic/cdr_loop_filter.sv
logic/cdr_state_sampler.sv
logic/mm_cdr_top.sv
tb/mm_cdr_props.sv
tb/tb_mm_cdr.sv
